// ==== divPkg.sv ====
// ****************************************
// shared types for the integer divide unit
// holds the controller states, the result kinds of a
// request and the flag struct that travels with the operands
// import inside a module body, use scoped names in port lists
// ****************************************

package divPkg;

    // ****************************************
    // controller states
    // ****************************************
    typedef enum logic [1:0] {
        stIdle    = 2'd0,
        stIterate = 2'd1,
        stDone    = 2'd2
    } divStateE;

    // ****************************************
    // result kinds decided before any iteration
    // ****************************************
    // kindNormal runs the shift-and-subtract loop,
    // the other two load their RISC-V results directly
    typedef enum logic [1:0] {
        kindNormal   = 2'd0,
        kindByZero   = 2'd1,
        kindOverflow = 2'd2
    } divKindE;

    // operand flags produced by the prep stage
    typedef struct packed {
        divKindE kind;
        // negate quotient at the output
        logic    quotNeg;
        // negate remainder at the output
        logic    remNeg;
    } divFlagsS;

    // flags of an unsigned or special request
    localparam divFlagsS flagsNone = '{
        kind:    kindNormal,
        quotNeg: 1'b0,
        remNeg:  1'b0
    };

endpackage

// ==== divOperandPrep.sv ====
// ****************************************
// operand preparation for the divide unit
// converts signed operands to magnitudes and classifies
// the request as normal, divide by zero or signed overflow
// purely combinational, evaluated every cycle
// ****************************************

module divOperandPrep #(
    parameter int width = 32
) (
    input  logic                isSigned,
    input  logic [width-1:0]    dividend,
    input  logic [width-1:0]    divisor,
    output logic [width-1:0]    dividendMag,
    output logic [width-1:0]    divisorMag,
    output divPkg::divFlagsS    flags
);
    import divPkg::*;

    // most negative signed value
    localparam logic [width-1:0] minSigned = {1'b1, {(width-1){1'b0}}};

    logic dividendSign;
    logic divisorSign;
    logic isByZero;
    logic isOverflow;

    // sign bits only count for signed requests
    assign dividendSign = isSigned & dividend[width-1];
    assign divisorSign  = isSigned & divisor[width-1];

    // two's complement magnitudes
    // minSigned maps onto itself, which is its correct unsigned magnitude
    assign dividendMag = dividendSign ? (~dividend + 1'b1) : dividend;
    assign divisorMag  = divisorSign ? (~divisor + 1'b1) : divisor;

    assign isByZero   = (divisor == '0);
    assign isOverflow = isSigned && (dividend == minSigned) && (divisor == '1);

    always_comb begin
        flags = flagsNone;
        if (isByZero) begin
            flags.kind = kindByZero;
        end else if (isOverflow) begin
            flags.kind = kindOverflow;
        end else begin
            flags.kind = kindNormal;
            // quotient sign from both operands, remainder follows the dividend
            flags.quotNeg = dividendSign ^ divisorSign;
            flags.remNeg  = dividendSign;
        end
    end

endmodule

// ==== divControl.sv ====
// ****************************************
// sequencing FSM of the divide unit
// accepts start in idle, issues one step per cycle while
// iterating and raises done for one cycle at the end
// stall freezes the FSM, flush drops the request in flight
// ****************************************

module divControl (
    input  logic            clk,
    input  logic            arstN,
    input  logic            start,
    input  divPkg::divKindE kind,
    input  logic            last,
    input  logic            stall,
    input  logic            flush,
    output logic            load,
    output logic            step,
    output logic            done
);
    import divPkg::*;

    divStateE state;
    divStateE stateNext;

    // ****************************************
    // next state and strobes
    // ****************************************
    always_comb begin
        stateNext = state;
        load      = 1'b0;
        step      = 1'b0;

        case (state)
            stIdle: begin
                if (start) begin
                    load = 1'b1;
                    // special results are ready right after the load
                    stateNext = (kind == kindNormal) ? stIterate : stDone;
                end
            end
            stIterate: begin
                step = 1'b1;
                // last coincides with the final step
                if (last) begin
                    stateNext = stDone;
                end
            end
            stDone: begin
                stateNext = stIdle;
            end
            default: begin
                stateNext = stIdle;
            end
        endcase

        // stall holds everything
        if (stall) begin
            stateNext = state;
            load      = 1'b0;
            step      = 1'b0;
        end

        // flush wins over stall and start
        if (flush) begin
            stateNext = stIdle;
            load      = 1'b0;
            step      = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= stIdle;
        end else begin
            state <= stateNext;
        end
    end

    // stays high through a stall in stDone
    assign done = (state == stDone);

endmodule

// ==== divStepCounter.sv ====
// ****************************************
// iteration step counter
// cleared on every load or flush, advanced once per step,
// last marks the final quotient bit of a division
// ****************************************

module divStepCounter #(
    parameter int width = 32
) (
    input  logic clk,
    input  logic arstN,
    input  logic clear,
    input  logic advance,
    output logic last
);
    // counts 0 .. width-1
    localparam int countBits = (width > 1) ? $clog2(width) : 1;
    localparam logic [countBits-1:0] lastCount = countBits'(width - 1);

    logic [countBits-1:0] count;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (advance) begin
            // wraps to zero after the final step
            count <= count + 1'b1;
        end
    end

    // high during the step that produces the last quotient bit
    assign last = (count == lastCount);

endmodule

// ==== divCore.sv ====
// ****************************************
// datapath of the divide unit
// restoring shift-and-subtract on operand magnitudes,
// one quotient bit per step, signs restored at the output
// special results are written directly on load
// ****************************************

module divCore #(
    parameter int width = 32
) (
    input  logic                clk,
    input  logic                arstN,
    input  logic                load,
    input  logic                step,
    input  logic [width-1:0]    dividendMag,
    input  logic [width-1:0]    divisorMag,
    input  logic [width-1:0]    dividend,
    input  divPkg::divFlagsS    flags,
    output logic [width-1:0]    quotient,
    output logic [width-1:0]    remainder
);
    import divPkg::*;

    // ****************************************
    // state
    // ****************************************
    // partial remainder stays below the divisor between steps
    logic [width-1:0] partRem;
    // dividend bits still to be brought down msb first
    logic [width-1:0] shifter;
    logic [width-1:0] divisorReg;
    logic [width-1:0] quotReg;
    logic             quotNegReg;
    logic             remNegReg;

    // ****************************************
    // one restoring step
    // ****************************************
    logic [width:0] trial;
    logic [width:0] diff;
    logic           fits;

    // bring down the next dividend bit
    assign trial = {partRem, shifter[width-1]};
    assign diff  = trial - {1'b0, divisorReg};
    // keep the difference when it did not go negative
    assign fits  = ~diff[width];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            partRem    <= '0;
            shifter    <= '0;
            divisorReg <= '0;
            quotReg    <= '0;
            quotNegReg <= 1'b0;
            remNegReg  <= 1'b0;
        end else if (load) begin
            case (flags.kind)
                kindByZero: begin
                    // RISC-V gives all ones and the dividend as remainder
                    quotReg <= '1;
                    partRem <= dividend;
                end
                kindOverflow: begin
                    // RISC-V gives the dividend as quotient and a zero remainder
                    quotReg <= dividend;
                    partRem <= '0;
                end
                default: begin
                    quotReg <= '0;
                    partRem <= '0;
                end
            endcase
            shifter    <= dividendMag;
            divisorReg <= divisorMag;
            // special results are already final and need no sign fixup
            quotNegReg <= (flags.kind == kindNormal) ? flags.quotNeg : 1'b0;
            remNegReg  <= (flags.kind == kindNormal) ? flags.remNeg : 1'b0;
        end else if (step) begin
            partRem <= fits ? diff[width-1:0] : trial[width-1:0];
            shifter <= {shifter[width-2:0], 1'b0};
            quotReg <= {quotReg[width-2:0], fits};
        end
    end

    // ****************************************
    // sign correction
    // ****************************************
    assign quotient  = quotNegReg ? (~quotReg + 1'b1) : quotReg;
    assign remainder = remNegReg ? (~partRem + 1'b1) : partRem;

endmodule

// ==== divTop.sv ====
// ****************************************
// integer divide unit, top level
// one signed or unsigned division at a time, width+1
// cycles from start to done, special cases in one cycle
// results are valid only in the cycle where done is high
// ****************************************

module divTop #(
    parameter int width = 32
) (
    input  logic             clk,
    input  logic             arstN,
    input  logic             start,
    input  logic             isSigned,
    input  logic [width-1:0] dividend,
    input  logic [width-1:0] divisor,
    input  logic             stall,
    input  logic             flush,
    output logic             done,
    output logic [width-1:0] quotient,
    output logic [width-1:0] remainder
);
    import divPkg::*;

    logic [width-1:0] dividendMag;
    logic [width-1:0] divisorMag;
    divFlagsS         flags;
    logic             load;
    logic             step;
    logic             last;
    logic             counterClear;

    divOperandPrep #(.width(width)) u_divOperandPrep (
        .isSigned    (isSigned),
        .dividend    (dividend),
        .divisor     (divisor),
        .dividendMag (dividendMag),
        .divisorMag  (divisorMag),
        .flags       (flags)
    );

    divControl u_divControl (
        .clk   (clk),
        .arstN (arstN),
        .start (start),
        .kind  (flags.kind),
        .last  (last),
        .stall (stall),
        .flush (flush),
        .load  (load),
        .step  (step),
        .done  (done)
    );

    // restart the count on every request and after a dropped one
    assign counterClear = load | flush;

    divStepCounter #(.width(width)) u_divStepCounter (
        .clk     (clk),
        .arstN   (arstN),
        .clear   (counterClear),
        .advance (step),
        .last    (last)
    );

    divCore #(.width(width)) u_divCore (
        .clk         (clk),
        .arstN       (arstN),
        .load        (load),
        .step        (step),
        .dividendMag (dividendMag),
        .divisorMag  (divisorMag),
        .dividend    (dividend),
        .flags       (flags),
        .quotient    (quotient),
        .remainder   (remainder)
    );

endmodule

// ==== divTb.sv ====
// ****************************************
// self-checking testbench for the divide unit
// drives random and directed divisions into divTop, compares
// the results with a reference model and checks done timing,
// stall delay and flush behavior
// ****************************************

module divTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int width = 32;
    localparam logic [width-1:0] minSigned = {1'b1, {(width-1){1'b0}}};

    logic clk = 1'b0;
    logic arstN;
    logic start;
    logic isSigned;
    logic [width-1:0] dividend;
    logic [width-1:0] divisor;
    logic stall;
    logic flush;
    logic done;
    logic [width-1:0] quotient;
    logic [width-1:0] remainder;

    logic [width-1:0] expQuot;
    logic [width-1:0] expRem;
    // set while a division is in flight and its done is still due
    logic pending;
    logic [31:0] rngState;
    int errCount;
    int failCount;

    always #5 clk = ~clk;

    divTop #(.width(width)) u_divTop (
        .clk       (clk),
        .arstN     (arstN),
        .start     (start),
        .isSigned  (isSigned),
        .dividend  (dividend),
        .divisor   (divisor),
        .stall     (stall),
        .flush     (flush),
        .done      (done),
        .quotient  (quotient),
        .remainder (remainder)
    );

    // ****************************************
    // checks on every done cycle
    // ****************************************
    assert property (@(posedge clk) disable iff (!arstN) done |-> pending)
        else begin
            failCount++;
            $display("done went high with no division due");
        end

    assert property (@(posedge clk) disable iff (!arstN) done |-> (quotient == expQuot))
        else begin
            errCount++;
            $display("ERR quotient got %h expected %h", $sampled(quotient), $sampled(expQuot));
        end

    assert property (@(posedge clk) disable iff (!arstN) done |-> (remainder == expRem))
        else begin
            errCount++;
            $display("ERR remainder got %h expected %h", $sampled(remainder), $sampled(expRem));
        end

    // ****************************************
    // stimulus and reference helpers
    // ****************************************
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // truncating division where the remainder takes the dividend sign
    function automatic logic [2*width-1:0] refDivide(input logic sgn,
                                                     input logic [width-1:0] a,
                                                     input logic [width-1:0] b);
        logic [width-1:0] q;
        logic [width-1:0] r;
        if (b == '0) begin
            q = '1;
            r = a;
        end else if (sgn && a == minSigned && b == '1) begin
            q = a;
            r = '0;
        end else if (sgn) begin
            q = $signed(a) / $signed(b);
            r = $signed(a) % $signed(b);
        end else begin
            q = a / b;
            r = a % b;
        end
        return {q, r};
    endfunction

    task automatic drawOperands(output logic [width-1:0] a, output logic [width-1:0] b);
        int shift;
        rngState = xorshift(rngState);
        a = rngState;
        rngState = xorshift(rngState);
        shift = int'(rngState[4:0]) % (width - 4);
        rngState = xorshift(rngState);
        // narrow the divisor so quotients of many sizes show up
        b = $signed(rngState) >>> shift;
        if (b == '0) begin
            b = 'd3;
        end
    endtask

    task automatic checkIdle(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk);
            #1;
            if (done) begin
                failCount++;
                $display("done went high before any start");
            end
        end
    endtask

    // one division with an optional stall of stallLen cycles from cycle stallAt
    task automatic runDivision(input logic sgn, input logic [width-1:0] a,
                               input logic [width-1:0] b, input int stallAt,
                               input int stallLen);
        logic special;
        int cycles;
        int expCycles;
        special = (b == '0) || (sgn && a == minSigned && b == '1);
        expCycles = (special ? 1 : width + 1) + stallLen;
        @(posedge clk);
        #1;
        isSigned = sgn;
        dividend = a;
        divisor = b;
        start = 1'b1;
        {expQuot, expRem} = refDivide(sgn, a, b);
        pending = 1'b1;
        cycles = 0;
        do begin
            @(posedge clk);
            #1;
            start = 1'b0;
            cycles++;
            stall = (stallLen > 0) && (cycles >= stallAt) && (cycles < stallAt + stallLen);
        end while (!done && cycles < expCycles + 10);
        stall = 1'b0;
        if (!done) begin
            failCount++;
            $display("timeout, no done within %0d cycles of start", cycles);
        end else if (cycles != expCycles) begin
            errCount++;
            $display("ERR doneLatency got %h expected %h", cycles, expCycles);
        end
        @(posedge clk);
        #1;
        pending = 1'b0;
        if (done) begin
            failCount++;
            $display("done stayed high for more than one cycle");
        end
    endtask

    // start a division, flush it and watch that no done follows
    task automatic flushDivision(input logic [width-1:0] a, input logic [width-1:0] b,
                                 input int flushAt);
        int cycles;
        @(posedge clk);
        #1;
        isSigned = 1'b0;
        dividend = a;
        divisor = b;
        start = 1'b1;
        pending = 1'b1;
        cycles = 0;
        do begin
            @(posedge clk);
            #1;
            start = 1'b0;
            cycles++;
            flush = (cycles == flushAt);
            if (flush) begin
                pending = 1'b0;
            end
            if (done && cycles > flushAt) begin
                failCount++;
                $display("done appeared after the division was flushed");
            end
        end while (cycles < flushAt + width + 2);
    endtask

    // ****************************************
    // test sequence
    // ****************************************
    initial begin
        logic [width-1:0] a;
        logic [width-1:0] b;
        arstN = 1'b0;
        start = 1'b0;
        isSigned = 1'b0;
        dividend = '0;
        divisor = '0;
        stall = 1'b0;
        flush = 1'b0;
        expQuot = '0;
        expRem = '0;
        pending = 1'b0;
        rngState = 32'd29;
        errCount = 0;
        failCount = 0;
        repeat (10) @(posedge clk);
        #1;
        arstN = 1'b1;
        checkIdle(20);

        for (int i = 0; i < 40; i++) begin
            drawOperands(a, b);
            runDivision(1'b0, a, b, 0, 0);
        end
        for (int i = 0; i < 40; i++) begin
            drawOperands(a, b);
            runDivision(1'b1, a, b, 0, 0);
        end
        runDivision(1'b1, -32'sd7, 32'sd2, 0, 0);
        runDivision(1'b1, 32'sd7, -32'sd2, 0, 0);
        runDivision(1'b1, minSigned, 32'd1, 0, 0);
        runDivision(1'b0, minSigned, '1, 0, 0);

        // special cases finish one cycle after start
        runDivision(1'b0, 32'h1234_5678, '0, 0, 0);
        runDivision(1'b1, 32'hdead_beef, '0, 0, 0);
        runDivision(1'b1, minSigned, '1, 0, 0);

        for (int k = 1; k <= 6; k++) begin
            drawOperands(a, b);
            runDivision(k[0], a, b, 5, k);
        end

        drawOperands(a, b);
        flushDivision(a, b, 10);
        drawOperands(a, b);
        runDivision(1'b1, a, b, 0, 0);

        $display("value errors %0d, other failures %0d", errCount, failCount);
        if (errCount == 0 && failCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
divPkg.sv
divOperandPrep.sv
divControl.sv
divStepCounter.sv
divCore.sv
divTop.sv
divTb.sv

// ==== run.sh ====
#!/bin/sh
# compile with Verilator, run, and pass only if the pass message is printed
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f flist.f --top-module divTb -o divTbSim &&
out=$(./obj_dir/divTbSim) &&
echo "$out" &&
echo "$out" | grep -qx "Finished with no errors" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
